/* tb.f */
+incdir+tests
logic/mem_cache_pkg.sv
logic/miss_timer.sv
logic/cache_port_ctrl.sv
logic/line_store.sv
logic/backing_mem.sv
logic/mem_cache_top.sv
tests/tb_mem_cache.sv

/* Bender.yml */
package:
  name: mem_cache

sources:
  - files:
      - logic/mem_cache_pkg.sv
      - logic/miss_timer.sv
      - logic/cache_port_ctrl.sv
      - logic/line_store.sv
      - logic/backing_mem.sv
      - logic/mem_cache_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_mem_cache.sv

/* tests/cache_ref_model.svh */
`ifndef CACHE_REF_MODEL_SVH
`define CACHE_REF_MODEL_SVH

// expected contents of the backing memory and both caches
// cache words are kept flat, slot = line index * words per line + offset
mem_cache_pkg::word_t mem_model [mem_cache_pkg::MEM_WORDS];

bit ic_valid [LINES];
int ic_tag [LINES];
mem_cache_pkg::word_t ic_words [LINES * mem_cache_pkg::LINE_WORDS];

bit dc_valid [LINES];
bit dc_dirty [LINES];
int dc_tag [LINES];
mem_cache_pkg::word_t dc_words [LINES * mem_cache_pkg::LINE_WORDS];

function automatic int line_index(input int addr);
	return (addr / mem_cache_pkg::LINE_WORDS) % LINES;
endfunction

function automatic int line_tag(input int addr);
	return addr / (mem_cache_pkg::LINE_WORDS * LINES);
endfunction

function automatic int word_slot(input int addr);
	return line_index(addr) * mem_cache_pkg::LINE_WORDS + addr % mem_cache_pkg::LINE_WORDS;
endfunction

function automatic bit icache_hits(input int addr);
	return ic_valid[line_index(addr)] && (ic_tag[line_index(addr)] == line_tag(addr));
endfunction

function automatic bit dcache_hits(input int addr);
	return dc_valid[line_index(addr)] && (dc_tag[line_index(addr)] == line_tag(addr));
endfunction

function automatic bit victim_dirty(input int addr);
	return dc_valid[line_index(addr)] && dc_dirty[line_index(addr)];
endfunction

task automatic reset_model();
	for (int i = 0; i < mem_cache_pkg::MEM_WORDS; i++) begin
		mem_model[i] = '0;
	end
	for (int l = 0; l < LINES; l++) begin
		ic_valid[l] = 1'b0;
		dc_valid[l] = 1'b0;
		dc_dirty[l] = 1'b0;
	end
endtask

// whole aligned line comes from memory as it stands now
task automatic fill_icache(input int addr);
	int base;
	int idx;
	base = addr - addr % mem_cache_pkg::LINE_WORDS;
	idx = line_index(addr);
	for (int w = 0; w < mem_cache_pkg::LINE_WORDS; w++) begin
		ic_words[idx * mem_cache_pkg::LINE_WORDS + w] = mem_model[(base + w) % mem_cache_pkg::MEM_WORDS];
	end
	ic_valid[idx] = 1'b1;
	ic_tag[idx] = line_tag(addr);
endtask

task automatic fill_dcache(input int addr);
	int base;
	int idx;
	base = addr - addr % mem_cache_pkg::LINE_WORDS;
	idx = line_index(addr);
	for (int w = 0; w < mem_cache_pkg::LINE_WORDS; w++) begin
		dc_words[idx * mem_cache_pkg::LINE_WORDS + w] = mem_model[(base + w) % mem_cache_pkg::MEM_WORDS];
	end
	dc_valid[idx] = 1'b1;
	dc_dirty[idx] = 1'b0;
	dc_tag[idx] = line_tag(addr);
endtask

// victim base address is rebuilt from its stored tag and the index
task automatic write_back_victim(input int addr);
	int base;
	int idx;
	idx = line_index(addr);
	base = (dc_tag[idx] * LINES + idx) * mem_cache_pkg::LINE_WORDS;
	for (int w = 0; w < mem_cache_pkg::LINE_WORDS; w++) begin
		mem_model[(base + w) % mem_cache_pkg::MEM_WORDS] = dc_words[idx * mem_cache_pkg::LINE_WORDS + w];
	end
endtask

task automatic store_dcache_word(input int addr, input mem_cache_pkg::word_t wdata);
	dc_words[word_slot(addr)] = wdata;
	dc_dirty[line_index(addr)] = 1'b1;
endtask

`endif

/* tests/tb_mem_cache.sv */
`timescale 1ns/10ps

module tb_mem_cache;

	localparam int LINES = 8;
	localparam int MISS_LATENCY = 5;
	localparam int PERIOD = 40;
	localparam int N_RANDOM = 400;
	localparam int N_DIRECTED = 11;
	// dirty miss, fill, retry and one spare cycle
	localparam int WORST_CYCLES = 2 * MISS_LATENCY + 3;
	localparam int N_TXN = N_DIRECTED + 2 * N_RANDOM;
	localparam int LIMIT_CYCLES = N_TXN * 2 * WORST_CYCLES + 200;

	logic clk;
	logic reset_n;
	logic inst_read;
	mem_cache_pkg::addr_t inst_addr;
	mem_cache_pkg::word_t inst_data;
	logic inst_busy;
	logic data_read;
	logic data_write;
	mem_cache_pkg::addr_t data_addr;
	mem_cache_pkg::word_t data_wdata;
	mem_cache_pkg::word_t data_rdata;
	logic data_busy;

	int errors = 0;
	int checks = 0;
	int unsigned seed = 32'h027f_9fa0;

	`include "cache_ref_model.svh"

	mem_cache_top #(
		.LINES        (LINES),
		.MISS_LATENCY (MISS_LATENCY)
	) uut (
		.clk       (clk),
		.reset_n   (reset_n),
		.i_i_read  (inst_read),
		.i_i_addr  (inst_addr),
		.o_i_data  (inst_data),
		.o_i_busy  (inst_busy),
		.i_d_read  (data_read),
		.i_d_write (data_write),
		.i_d_addr  (data_addr),
		.i_d_wdata (data_wdata),
		.o_d_rdata (data_rdata),
		.o_d_busy  (data_busy)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

	initial begin
		#(LIMIT_CYCLES * PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles", LIMIT_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0d ns: %s expected %0h, got %0h",
				$time, name, expected, actual);
		end
	endtask

	// starts on a falling edge and returns on the falling edge where the word was checked
	task automatic fetch_instr(input int addr);
		bit hit;
		int busy_cycles;
		hit = icache_hits(addr);
		busy_cycles = 0;
		inst_read = 1'b1;
		inst_addr = mem_cache_pkg::addr_t'(addr);
		@(negedge clk);
		check_value("o_i_busy", !hit, inst_busy);
		if (!hit) begin
			while (inst_busy) begin
				busy_cycles++;
				@(negedge clk);
			end
			check_value("o_i_busy length", MISS_LATENCY, busy_cycles);
			// busy fell on the fill edge and the retry serves one cycle later
			fill_icache(addr);
			@(negedge clk);
		end
		check_value("o_i_data", ic_words[word_slot(addr)], inst_data);
	endtask

	task automatic access_data(input bit write, input int addr, input mem_cache_pkg::word_t wdata);
		bit hit;
		bit dirty;
		int busy_cycles;
		hit = dcache_hits(addr);
		dirty = !hit && victim_dirty(addr);
		busy_cycles = 0;
		data_read = !write;
		data_write = write;
		data_addr = mem_cache_pkg::addr_t'(addr);
		data_wdata = wdata;
		@(negedge clk);
		check_value("o_d_busy", !hit, data_busy);
		if (!hit) begin
			while (data_busy) begin
				busy_cycles++;
				// victim reached memory on the edge just passed and is modelled after the next
				// rising edge so an instruction fill on that edge still sees old data
				if (dirty && busy_cycles == MISS_LATENCY + 1) begin
					@(posedge clk);
					write_back_victim(addr);
				end
				@(negedge clk);
			end
			check_value("o_d_busy length", dirty ? 2 * MISS_LATENCY : MISS_LATENCY, busy_cycles);
			fill_dcache(addr);
			@(negedge clk);
		end
		if (write) begin
			store_dcache_word(addr, wdata);
		end else begin
			check_value("o_d_rdata", dc_words[word_slot(addr)], data_rdata);
		end
	endtask

	function automatic int pick_addr();
		// half the traffic stays low so both ports share lines
		if ($urandom_range(0, 1) == 1) begin
			return $urandom_range(0, 63);
		end
		return $urandom_range(0, mem_cache_pkg::MEM_WORDS - 1);
	endfunction

	initial begin
		void'($urandom(seed));
		reset_n = 1'b0;
		inst_read = 1'b0;
		inst_addr = '0;
		data_read = 1'b0;
		data_write = 1'b0;
		data_addr = '0;
		data_wdata = '0;
		reset_model();
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		@(negedge clk);
		check_value("o_i_busy", 0, inst_busy);
		check_value("o_d_busy", 0, data_busy);
		check_value("o_i_data", 0, inst_data);
		check_value("o_d_rdata", 0, data_rdata);

		// cold misses followed by hits in the filled lines
		fetch_instr(16'h0024);
		access_data(1'b0, 16'h0024, '0);
		fetch_instr(16'h0025);
		access_data(1'b0, 16'h0026, '0);
		access_data(1'b1, 16'h0027, 16'hbeef);
		access_data(1'b0, 16'h0027, '0);
		// instruction side still holds the stale line
		fetch_instr(16'h0027);
		// same index with another tag sends the dirty victim out first
		access_data(1'b0, 16'h0007, '0);
		access_data(1'b0, 16'h0027, '0);
		fetch_instr(16'h0007);
		fetch_instr(16'h0027);
		inst_read = 1'b0;
		data_read = 1'b0;
		data_write = 1'b0;
		@(negedge clk);

		fork
			begin
				for (int n = 0; n < N_RANDOM; n++) begin
					fetch_instr(pick_addr());
					if ($urandom_range(0, 3) == 0) begin
						inst_read = 1'b0;
						repeat ($urandom_range(1, 2)) @(negedge clk);
					end
				end
				inst_read = 1'b0;
			end
			begin
				for (int n = 0; n < N_RANDOM; n++) begin
					access_data($urandom_range(0, 1) == 1, pick_addr(),
						mem_cache_pkg::word_t'($urandom));
					if ($urandom_range(0, 3) == 0) begin
						data_read = 1'b0;
						data_write = 1'b0;
						repeat ($urandom_range(1, 2)) @(negedge clk);
					end
				end
				data_read = 1'b0;
				data_write = 1'b0;
			end
		join

		repeat (2) @(negedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* logic/mem_cache_top.sv */
`timescale 1ns/10ps

module mem_cache_top #(
	parameter int LINES = 8,
	parameter int MISS_LATENCY = 5
) (
	input  logic                  clk,
	input  logic                  reset_n,

	input  logic                  i_i_read,
	input  mem_cache_pkg::addr_t  i_i_addr,
	output mem_cache_pkg::word_t  o_i_data,
	output logic                  o_i_busy,

	input  logic                  i_d_read,
	input  logic                  i_d_write,
	input  mem_cache_pkg::addr_t  i_d_addr,
	input  mem_cache_pkg::word_t  i_d_wdata,
	output mem_cache_pkg::word_t  o_d_rdata,
	output logic                  o_d_busy
);

	// instruction side
	logic ic_hit;
	logic ic_victim_dirty;
	logic ic_timer_start;
	logic ic_timer_done;
	logic ic_word_re;
	logic ic_word_we;
	logic ic_fill;
	mem_cache_pkg::line_t ic_fill_line;

	// data side
	logic dc_hit;
	logic dc_victim_dirty;
	logic dc_timer_start;
	logic dc_timer_done;
	logic dc_word_re;
	logic dc_word_we;
	logic dc_fill;
	logic dc_mem_we;
	mem_cache_pkg::addr_t dc_victim_addr;
	mem_cache_pkg::line_t dc_victim_line;
	mem_cache_pkg::line_t dc_fill_line;

	// read-only port with its write request tied low
	cache_port_ctrl #(.WRITE_BACK(1'b0)) u_i_ctrl (
		.clk            (clk),
		.reset_n        (reset_n),
		.i_read         (i_i_read),
		.i_write        (1'b0),
		.i_hit          (ic_hit),
		.i_victim_dirty (ic_victim_dirty),
		.i_timer_done   (ic_timer_done),
		.o_timer_start  (ic_timer_start),
		.o_word_re      (ic_word_re),
		.o_word_we      (ic_word_we),
		.o_fill         (ic_fill),
		.o_mem_we       (),
		.o_busy         (o_i_busy)
	);

	miss_timer #(.MISS_LATENCY(MISS_LATENCY)) u_i_timer (
		.clk       (clk),
		.reset_n   (reset_n),
		.i_start   (ic_timer_start),
		.o_done    (ic_timer_done),
		.o_running ()
	);

	line_store #(.LINES(LINES)) u_i_store (
		.clk            (clk),
		.reset_n        (reset_n),
		.i_addr         (i_i_addr),
		.i_wdata        ('0),
		.i_word_re      (ic_word_re),
		.i_word_we      (ic_word_we),
		.i_fill         (ic_fill),
		.i_fill_line    (ic_fill_line),
		.o_hit          (ic_hit),
		.o_victim_dirty (ic_victim_dirty),
		.o_victim_addr  (),
		.o_victim_line  (),
		.o_rdata        (o_i_data)
	);

	cache_port_ctrl #(.WRITE_BACK(1'b1)) u_d_ctrl (
		.clk            (clk),
		.reset_n        (reset_n),
		.i_read         (i_d_read),
		.i_write        (i_d_write),
		.i_hit          (dc_hit),
		.i_victim_dirty (dc_victim_dirty),
		.i_timer_done   (dc_timer_done),
		.o_timer_start  (dc_timer_start),
		.o_word_re      (dc_word_re),
		.o_word_we      (dc_word_we),
		.o_fill         (dc_fill),
		.o_mem_we       (dc_mem_we),
		.o_busy         (o_d_busy)
	);

	miss_timer #(.MISS_LATENCY(MISS_LATENCY)) u_d_timer (
		.clk       (clk),
		.reset_n   (reset_n),
		.i_start   (dc_timer_start),
		.o_done    (dc_timer_done),
		.o_running ()
	);

	line_store #(.LINES(LINES)) u_d_store (
		.clk            (clk),
		.reset_n        (reset_n),
		.i_addr         (i_d_addr),
		.i_wdata        (i_d_wdata),
		.i_word_re      (dc_word_re),
		.i_word_we      (dc_word_we),
		.i_fill         (dc_fill),
		.i_fill_line    (dc_fill_line),
		.o_hit          (dc_hit),
		.o_victim_dirty (dc_victim_dirty),
		.o_victim_addr  (dc_victim_addr),
		.o_victim_line  (dc_victim_line),
		.o_rdata        (o_d_rdata)
	);

	backing_mem u_mem (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_a_addr    (i_i_addr),
		.o_a_line    (ic_fill_line),
		.i_b_addr    (i_d_addr),
		.o_b_line    (dc_fill_line),
		.i_b_we      (dc_mem_we),
		.i_b_wb_addr (dc_victim_addr),
		.i_b_wb_line (dc_victim_line)
	);

endmodule

/* logic/backing_mem.sv */
`timescale 1ns/10ps

module backing_mem (
	input  logic                  clk,
	input  logic                  reset_n,
	input  mem_cache_pkg::addr_t  i_a_addr,
	output mem_cache_pkg::line_t  o_a_line,
	input  mem_cache_pkg::addr_t  i_b_addr,
	output mem_cache_pkg::line_t  o_b_line,
	input  logic                  i_b_we,
	input  mem_cache_pkg::addr_t  i_b_wb_addr,
	input  mem_cache_pkg::line_t  i_b_wb_line
);

	localparam int OFF_W = mem_cache_pkg::OFFSET_W;
	localparam int BLK_W = mem_cache_pkg::MEM_AW - OFF_W;

	mem_cache_pkg::word_t mem_q [mem_cache_pkg::MEM_WORDS];

	logic [BLK_W-1:0] a_blk;
	logic [BLK_W-1:0] b_blk;
	logic [BLK_W-1:0] wb_blk;

	// upper address bits fall outside the reduced memory
	assign a_blk = i_a_addr[OFF_W +: BLK_W];
	assign b_blk = i_b_addr[OFF_W +: BLK_W];
	assign wb_blk = i_b_wb_addr[OFF_W +: BLK_W];

	// reads see the contents before a writeback on the same edge
	always_comb begin
		for (int w = 0; w < mem_cache_pkg::LINE_WORDS; w++) begin
			o_a_line[w] = mem_q[{a_blk, OFF_W'(w)}];
			o_b_line[w] = mem_q[{b_blk, OFF_W'(w)}];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < mem_cache_pkg::MEM_WORDS; i++) begin
				mem_q[i] <= '0;
			end
		end else if (i_b_we) begin
			for (int w = 0; w < mem_cache_pkg::LINE_WORDS; w++) begin
				mem_q[{wb_blk, OFF_W'(w)}] <= i_b_wb_line[w];
			end
		end
	end

endmodule

/* logic/line_store.sv */
`timescale 1ns/10ps

module line_store #(
	parameter int LINES = 8
) (
	input  logic                  clk,
	input  logic                  reset_n,
	input  mem_cache_pkg::addr_t  i_addr,
	input  mem_cache_pkg::word_t  i_wdata,
	input  logic                  i_word_re,
	input  logic                  i_word_we,
	input  logic                  i_fill,
	input  mem_cache_pkg::line_t  i_fill_line,
	output logic                  o_hit,
	output logic                  o_victim_dirty,
	output mem_cache_pkg::addr_t  o_victim_addr,
	output mem_cache_pkg::line_t  o_victim_line,
	output mem_cache_pkg::word_t  o_rdata
);

	localparam int OFF_W = mem_cache_pkg::OFFSET_W;
	localparam int INDEX_W = $clog2(LINES);
	localparam int TAG_W = mem_cache_pkg::ADDR_W - INDEX_W - OFF_W;

	logic [TAG_W-1:0] tag_q [LINES];
	logic [LINES-1:0] valid_q;
	logic [LINES-1:0] dirty_q;
	mem_cache_pkg::line_t data_q [LINES];

	logic [TAG_W-1:0] req_tag;
	logic [INDEX_W-1:0] req_index;
	logic [OFF_W-1:0] req_offset;

	// tag | index | offset
	assign req_tag = i_addr[mem_cache_pkg::ADDR_W-1 -: TAG_W];
	assign req_index = i_addr[OFF_W +: INDEX_W];
	assign req_offset = i_addr[OFF_W-1:0];

	assign o_hit = valid_q[req_index] && (tag_q[req_index] == req_tag);

	// the indexed line is the victim whenever the request misses
	assign o_victim_dirty = valid_q[req_index] && dirty_q[req_index];
	assign o_victim_addr = {tag_q[req_index], req_index, {OFF_W{1'b0}}};
	assign o_victim_line = data_q[req_index];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_q <= '0;
			dirty_q <= '0;
			o_rdata <= '0;
		end else begin
			if (i_fill) begin
				valid_q[req_index] <= 1'b1;
				dirty_q[req_index] <= 1'b0;
			end else if (i_word_we) begin
				dirty_q[req_index] <= 1'b1;
			end
			if (i_word_re) begin
				o_rdata <= data_q[req_index][req_offset];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_fill) begin
			tag_q[req_index] <= req_tag;
			data_q[req_index] <= i_fill_line;
		end else if (i_word_we) begin
			data_q[req_index][req_offset] <= i_wdata;
		end
	end

endmodule

/* logic/cache_port_ctrl.sv */
`timescale 1ns/10ps

module cache_port_ctrl #(
	parameter bit WRITE_BACK = 1'b1
) (
	input  logic clk,
	input  logic reset_n,
	input  logic i_read,
	input  logic i_write,
	input  logic i_hit,
	input  logic i_victim_dirty,
	input  logic i_timer_done,
	output logic o_timer_start,
	output logic o_word_re,
	output logic o_word_we,
	output logic o_fill,
	output logic o_mem_we,
	output logic o_busy
);

	typedef enum logic [1:0] {
		IDLE,
		WRITEBACK,
		REFILL,
		RETRY
	} state_t;

	state_t state_q;
	state_t state_d;
	logic req_write;
	logic req_any;
	logic busy_q;

	// read-only port never sees a write, whatever sits on i_write
	assign req_write = WRITE_BACK && i_write;
	assign req_any = i_read || req_write;

	always_comb begin
		state_d = state_q;
		o_timer_start = 1'b0;
		o_word_re = 1'b0;
		o_word_we = 1'b0;
		o_fill = 1'b0;
		o_mem_we = 1'b0;
		case (state_q)
			IDLE: begin
				if (req_any && i_hit) begin
					o_word_re = i_read;
					o_word_we = req_write;
				end else if (req_any) begin
					o_timer_start = 1'b1;
					if (WRITE_BACK && i_victim_dirty) begin
						state_d = WRITEBACK;
					end else begin
						state_d = REFILL;
					end
				end
			end
			WRITEBACK: begin
				// victim goes out, then the same timer runs again for the refill
				if (i_timer_done) begin
					o_mem_we = 1'b1;
					o_timer_start = 1'b1;
					state_d = REFILL;
				end
			end
			REFILL: begin
				if (i_timer_done) begin
					o_fill = 1'b1;
					state_d = RETRY;
				end
			end
			RETRY: begin
				// the held request hits on the freshly filled line
				if (req_any && i_hit) begin
					o_word_re = i_read;
					o_word_we = req_write;
				end
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q <= IDLE;
			busy_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// busy covers the memory access only, it drops on the fill edge
			busy_q <= (state_d == WRITEBACK) || (state_d == REFILL);
		end
	end

	assign o_busy = busy_q;

endmodule

/* logic/miss_timer.sv */
`timescale 1ns/10ps

module miss_timer #(
	parameter int MISS_LATENCY = 5
) (
	input  logic clk,
	input  logic reset_n,
	input  logic i_start,
	output logic o_done,
	output logic o_running
);

	localparam int CNT_W = $clog2(MISS_LATENCY + 1);

	logic [CNT_W-1:0] count_q;

	// a start while counting reloads, used to chain writeback into refill
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			count_q <= '0;
		end else if (i_start) begin
			count_q <= CNT_W'(MISS_LATENCY);
		end else if (count_q != '0) begin
			count_q <= count_q - CNT_W'(1);
		end
	end

	assign o_running = (count_q != '0);

	// last cycle of the access
	assign o_done = (count_q == CNT_W'(1));

endmodule

/* logic/mem_cache_pkg.sv */
package mem_cache_pkg;

	// word and address widths shared by both ports
	localparam int WORD_W = 16;
	localparam int ADDR_W = 16;

	// four words per line, offset is the two low address bits
	localparam int LINE_WORDS = 4;
	localparam int OFFSET_W = $clog2(LINE_WORDS);

	// backing memory is reduced to 256 words, low eight address bits
	localparam int MEM_WORDS = 256;
	localparam int MEM_AW = $clog2(MEM_WORDS);

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// word 0 sits in the low bits
	typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

endpackage
